// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_spike_rate_monitor \
		-f filelist.f --Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log
	cat sim.log
	! grep -q "Test failed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/report_credit_tx.sv ====
`include "spike_rate_defs.svh"

module report_credit_tx (
    input  logic                       reset,
    input  logic                       clk,
    report_if.dst                      rep,
    input  logic                       credit_return,
    output logic                       out_valid,
    output spike_rate_pkg::report_word_u out_word
);

    import spike_rate_pkg::*;

    localparam int PTR_W  = $clog2(`REPORT_DEPTH);
    localparam int FILL_W = $clog2(`REPORT_DEPTH + 1);
    localparam int CRED_W = $clog2(`CREDIT_MAX + 1);

    localparam logic [FILL_W-1:0] FULL_LEVEL = FILL_W'(`REPORT_DEPTH);
    localparam logic [CRED_W-1:0] CRED_INIT  = CRED_W'(`CREDIT_MAX);
    localparam logic [PTR_W-1:0]  LAST_SLOT  = PTR_W'(`REPORT_DEPTH - 1);

    // queue storage
    report_word_u mem [`REPORT_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [FILL_W-1:0]  fill;
    logic [CRED_W-1:0]  credits;
    logic [`DROP_W-1:0] drop_cnt;

    logic full;
    logic empty;
    logic pop;
    logic accept;
    logic notice;
    logic wr_en;

    report_word_u rec_word;
    report_word_u notice_word;
    report_word_u wr_word;

    // circular pointer step
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == LAST_SLOT) ? '0 : p + 1'b1;
    endfunction

    // count record built from the incoming fields
    always_comb begin
        rec_word.cnt.kind    = REP_COUNT;
        rec_word.cnt.channel = rep.channel;
        rec_word.cnt.win_id  = rep.win_id;
        rec_word.cnt.count   = rep.count;
    end

    // drop notice carries the running drop tally
    always_comb begin
        notice_word.drop.kind    = REP_DROP;
        notice_word.drop.pad     = '0;
        notice_word.drop.dropped = drop_cnt;
    end

    assign full  = (fill == FULL_LEVEL);
    assign empty = (fill == '0);

    // send only with a word queued and a credit in hand
    assign pop = !empty && (credits != '0);

    // records win over notices, a notice waits for a push-free cycle
    assign accept  = rep.push && !full;
    assign notice  = (drop_cnt != '0) && !full && !rep.push;
    assign wr_en   = accept || notice;
    assign wr_word = accept ? rec_word : notice_word;

    // storage write
    always_ff @(posedge reset) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    // pointers and fill level
    always_ff @(posedge reset or negedge clk) begin
        if (!clk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // credit counter
    // consumer never returns more than it got, so no upper guard
    always_ff @(posedge reset or negedge clk) begin
        if (!clk) begin
            credits <= CRED_INIT;
        end else begin
            case ({pop, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // drop tally, saturating, cleared once its notice is queued
    always_ff @(posedge reset or negedge clk) begin
        if (!clk) begin
            drop_cnt <= '0;
        end else if (rep.push && full) begin
            if (drop_cnt != '1) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end else if (notice) begin
            drop_cnt <= '0;
        end
    end

    // head of queue goes straight out
    assign out_valid = pop;
    assign out_word  = mem[rd_ptr];

endmodule

// ==== design/report_if.sv ====
`include "spike_rate_defs.svh"

// count records from serializer to transmitter
// a record is taken in every cycle push is high, no stall path
interface report_if;

    logic                  push;
    logic [`CH_W-1:0]      channel;
    logic [`WIN_ID_W-1:0]  win_id;
    logic [`COUNT_W-1:0]   count;

    // record source side
    modport src (
        output push,
        output channel,
        output win_id,
        output count
    );

    // record sink side
    modport dst (
        input  push,
        input  channel,
        input  win_id,
        input  count
    );

endinterface

// ==== design/report_serializer.sv ====
`include "spike_rate_defs.svh"

module report_serializer (
    input  logic                                  reset,
    input  logic                                  clk,
    input  logic [`NUM_CH-1:0][`COUNT_W-1:0]      closed_counts,
    input  logic                                  close_valid,
    input  logic [`WIN_ID_W-1:0]                  win_id,
    report_if.src                                 rep
);

    localparam logic [`CH_W-1:0] LAST_CH = `CH_W'(`NUM_CH - 1);

    // walk state
    logic                 busy;
    logic [`CH_W-1:0]     ch_idx;

    // held copy of the closed window
    logic [`NUM_CH-1:0][`COUNT_W-1:0] snap_counts;
    logic [`WIN_ID_W-1:0]             snap_id;

    // start on close_valid, one channel per cycle, stop after the last
    // windows are long enough that a new close never lands mid-walk
    always_ff @(posedge reset or negedge clk) begin
        if (!clk) begin
            busy   <= 1'b0;
            ch_idx <= '0;
        end else if (close_valid) begin
            busy   <= 1'b1;
            ch_idx <= '0;
        end else if (busy) begin
            ch_idx <= ch_idx + 1'b1;
            if (ch_idx == LAST_CH) begin
                busy <= 1'b0;
            end
        end
    end

    // snapshot capture
    always_ff @(posedge reset) begin
        if (close_valid) begin
            snap_counts <= closed_counts;
            snap_id     <= win_id;
        end
    end

    // one record per busy cycle
    assign rep.push    = busy;
    assign rep.channel = ch_idx;
    assign rep.win_id  = snap_id;
    assign rep.count   = snap_counts[ch_idx];

endmodule

// ==== design/spike_input_sync.sv ====
`include "spike_rate_defs.svh"

module spike_input_sync (
    input  logic                reset,
    input  logic                clk,
    input  logic [`NUM_CH-1:0]  spike,
    input  logic                win_strobe,
    output logic [`NUM_CH-1:0]  spike_pulse,
    output logic                window_close
);

    // strobe rides along as the top bit so all lines see equal latency
    localparam int LINE_W = `NUM_CH + 1;

    logic [LINE_W-1:0] line_in;
    logic [LINE_W-1:0] sync_q1;
    logic [LINE_W-1:0] sync_q2;
    logic [LINE_W-1:0] line_dly;
    logic [LINE_W-1:0] edge_q;

    assign line_in = {win_strobe, spike};

    // two-flop synchronizer per line
    always_ff @(posedge reset or negedge clk) begin
        if (!clk) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= line_in;
            sync_q2 <= sync_q1;
        end
    end

    // delayed copy of the synced level, compared against the fresh one
    // edge_q is high for exactly one cycle per low-to-high transition
    always_ff @(posedge reset or negedge clk) begin
        if (!clk) begin
            line_dly <= '0;
            edge_q   <= '0;
        end else begin
            line_dly <= sync_q2;
            edge_q   <= sync_q2 & ~line_dly;
        end
    end

    // split back into spike pulses and window edge
    assign spike_pulse  = edge_q[`NUM_CH-1:0];
    assign window_close = edge_q[`NUM_CH];

endmodule

// ==== design/spike_rate_defs.svh ====
`ifndef SPIKE_RATE_DEFS_SVH
`define SPIKE_RATE_DEFS_SVH

// number of spike input lines
`define NUM_CH 4

// channel index width, log2 of NUM_CH
`define CH_W 2

// per-window spike count width, count saturates at all ones
`define COUNT_W 21

// window index width, wraps around
`define WIN_ID_W 8

// report queue entries
`define REPORT_DEPTH 8

// receiver buffer size, also the credit count after reset
`define CREDIT_MAX 4

// dropped record counter width, saturating
`define DROP_W 16

`endif

// ==== design/spike_rate_monitor.sv ====
`include "spike_rate_defs.svh"

module spike_rate_monitor (
    input  logic                reset,
    input  logic                clk,
    input  logic [`NUM_CH-1:0]  spike,
    input  logic                win_strobe,
    input  logic                credit_return,
    output logic                out_valid,
    output logic [31:0]         out_word
);

    import spike_rate_pkg::*;

    // synchronizer to counter
    logic [`NUM_CH-1:0] spike_pulse;
    logic               window_close;

    // counter to serializer
    logic [`NUM_CH-1:0][`COUNT_W-1:0] closed_counts;
    logic                             close_valid;
    logic [`WIN_ID_W-1:0]             win_id;

    // transmitter output word
    report_word_u tx_word;

    // serializer to transmitter
    report_if rep ();

    spike_input_sync i_spike_input_sync (
        .reset        (reset),
        .clk          (clk),
        .spike        (spike),
        .win_strobe   (win_strobe),
        .spike_pulse  (spike_pulse),
        .window_close (window_close)
    );

    spike_window_counter i_spike_window_counter (
        .reset         (reset),
        .clk           (clk),
        .spike_pulse   (spike_pulse),
        .window_close  (window_close),
        .closed_counts (closed_counts),
        .close_valid   (close_valid),
        .win_id        (win_id)
    );

    report_serializer i_report_serializer (
        .reset         (reset),
        .clk           (clk),
        .closed_counts (closed_counts),
        .close_valid   (close_valid),
        .win_id        (win_id),
        .rep           (rep.src)
    );

    report_credit_tx i_report_credit_tx (
        .reset         (reset),
        .clk           (clk),
        .rep           (rep.dst),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_word      (tx_word)
    );

    // flat 32-bit word at the pins
    assign out_word = tx_word;

endmodule

// ==== design/spike_rate_pkg.sv ====
`include "spike_rate_defs.svh"

package spike_rate_pkg;

    // top bit of every report word
    typedef enum logic {
        REP_COUNT = 1'b0,
        REP_DROP  = 1'b1
    } report_kind_e;

    // one channel's count for one closed window
    // 1 + 2 + 8 + 21 = 32 bits
    typedef struct packed {
        report_kind_e          kind;
        logic [`CH_W-1:0]      channel;
        logic [`WIN_ID_W-1:0]  win_id;
        logic [`COUNT_W-1:0]   count;
    } count_rec_t;

    // notice of records lost to a full queue
    // pad fills the word up to 32 bits
    typedef struct packed {
        report_kind_e          kind;
        logic [30-`DROP_W:0]   pad;
        logic [`DROP_W-1:0]    dropped;
    } drop_rec_t;

    // kind sits in bit 31 in both views and picks the reading
    typedef union packed {
        count_rec_t cnt;
        drop_rec_t  drop;
    } report_word_u;

endpackage

// ==== design/spike_window_counter.sv ====
`include "spike_rate_defs.svh"

module spike_window_counter (
    input  logic                                  reset,
    input  logic                                  clk,
    input  logic [`NUM_CH-1:0]                    spike_pulse,
    input  logic                                  window_close,
    output logic [`NUM_CH-1:0][`COUNT_W-1:0]      closed_counts,
    output logic                                  close_valid,
    output logic [`WIN_ID_W-1:0]                  win_id
);

    // counts of the window still open
    logic [`NUM_CH-1:0][`COUNT_W-1:0] open_counts;

    // index of the open window
    logic [`WIN_ID_W-1:0] open_id;

    // per-channel open counters
    always_ff @(posedge reset or negedge clk) begin
        if (!clk) begin
            open_counts <= '0;
        end else begin
            for (int ch = 0; ch < `NUM_CH; ch++) begin
                if (window_close) begin
                    // a pulse on the window edge opens the next window
                    open_counts[ch] <= {{(`COUNT_W-1){1'b0}}, spike_pulse[ch]};
                end else if (spike_pulse[ch] && (open_counts[ch] != '1)) begin
                    open_counts[ch] <= open_counts[ch] + 1'b1;
                end
            end
        end
    end

    // window bookkeeping
    // win_id names the window that has just been closed
    always_ff @(posedge reset or negedge clk) begin
        if (!clk) begin
            open_id     <= '0;
            win_id      <= '0;
            close_valid <= 1'b0;
        end else begin
            close_valid <= window_close;
            if (window_close) begin
                win_id  <= open_id;
                open_id <= open_id + 1'b1;
            end
        end
    end

    // snapshot of the closed window, valid along with close_valid
    always_ff @(posedge reset) begin
        if (window_close) begin
            closed_counts <= open_counts;
        end
    end

endmodule

// ==== filelist.f ====
+incdir+design
design/spike_rate_pkg.sv
design/report_if.sv
design/spike_input_sync.sv
design/spike_window_counter.sv
design/report_serializer.sv
design/report_credit_tx.sv
design/spike_rate_monitor.sv
verif/tb_clock_gen.sv
verif/tb_spike_rate_monitor.sv

// ==== verif/tb_clock_gen.sv ====
// clock and reset source for the testbench
// reset port carries the clock, clk port carries the active-low reset
module tb_clock_gen (
    output logic reset,
    output logic clk
);

    // period 100
    initial begin
        reset = 1'b0;
        forever #50 reset = ~reset;
    end

    // reset held low for 10 cycles, released just after an edge
    initial begin
        clk = 1'b0;
        repeat (10) @(posedge reset);
        #10;
        clk = 1'b1;
    end

endmodule

// ==== verif/tb_spike_rate_monitor.sv ====
`include "spike_rate_defs.svh"

module tb_spike_rate_monitor;

    localparam int NUM_WIN   = 260;
    localparam int WIN_LEN   = 64;
    localparam int HALF      = WIN_LEN / 2;
    localparam int RET_DELAY = 1;
    localparam int WATCHDOG  = ((NUM_WIN + 2) * WIN_LEN + 200) * 100;

    logic                reset;
    logic                clk;
    logic [`NUM_CH-1:0]  spike;
    logic                win_strobe;
    logic                credit_return;
    logic                out_valid;
    logic [31:0]         out_word;

    // stimulus and scoreboard state
    logic [31:0] lfsr;
    logic [31:0] exp_q[$];
    logic [31:0] exp_w;
    int          tally [`NUM_CH];
    bit          coinc [`NUM_CH];
    bit          hold;
    int          held_rx;
    int          kept;
    int          dropped;
    int          pending;
    int          ret_wait;
    int          errors;
    int          checked;
    string       test_name;

    tb_clock_gen i_tb_clock_gen (
        .reset (reset),
        .clk   (clk)
    );

    spike_rate_monitor i_spike_rate_monitor (
        .reset         (reset),
        .clk           (clk),
        .spike         (spike),
        .win_strobe    (win_strobe),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_word      (out_word)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic int draw_bits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    // expected report word: count record or drop notice
    // window index wraps, count and drop tally saturate
    function automatic logic [31:0] expected_word(input bit is_notice, input int ch,
                                                  input int win, input int tally_in);
        logic [31:0] w;
        int          sat;
        w = '0;
        if (is_notice) begin
            sat = (tally_in > (1 << `DROP_W) - 1) ? (1 << `DROP_W) - 1 : tally_in;
            w[31] = 1'b1;
            w[`DROP_W-1:0] = `DROP_W'(sat);
        end else begin
            sat = (tally_in > (1 << `COUNT_W) - 1) ? (1 << `COUNT_W) - 1 : tally_in;
            w[30 -: `CH_W] = `CH_W'(ch);
            w[30 - `CH_W -: `WIN_ID_W] = `WIN_ID_W'(win % (1 << `WIN_ID_W));
            w[`COUNT_W-1:0] = `COUNT_W'(sat);
        end
        return w;
    endfunction

    // closes with credits withheld: 2 for the credit limit, 4 for overflow
    function automatic bit is_held(input int w);
        return (w == 5) || (w == 6) || (w >= 10 && w <= 13);
    endfunction

    // records of a closing window, kept or dropped as the queue would
    task automatic queue_close(input int id);
        for (int ch = 0; ch < `NUM_CH; ch++) begin
            if (!hold || kept < `CREDIT_MAX + `REPORT_DEPTH) begin
                exp_q.push_back(expected_word(1'b0, ch, id, tally[ch]));
                kept++;
            end else begin
                dropped++;
            end
        end
    endtask

    // strobe high 2 cycles at window start
    // spikes 2 high 2 low, first edge on the strobe edge when coincident
    task automatic drive_cycles(input int from, input int upto);
        int start;
        for (int c = from; c < upto; c++) begin
            @(posedge reset);
            #10;
            win_strobe = (c < 2);
            for (int ch = 0; ch < `NUM_CH; ch++) begin
                start = coinc[ch] ? 0 : 2;
                spike[ch] = (c >= start) && (c < start + 4 * tally[ch]) &&
                            ((c - start) % 4 < 2);
            end
        end
    endtask

    // end of a hold period, queued words and any notice follow
    task automatic release_credits();
        assert (held_rx == `CREDIT_MAX) else begin
            errors++;
            $display("Fail %s: expected %0d words with credits held, actual %0d",
                     test_name, `CREDIT_MAX, held_rx);
        end
        if (dropped > 0) begin
            exp_q.push_back(expected_word(1'b1, 0, 0, dropped));
        end
        hold = 1'b0;
    endtask

    // consumer credit return, one pulse per word received
    initial begin
        credit_return = 1'b0;
        ret_wait      = RET_DELAY;
        forever begin
            @(posedge reset);
            #10;
            credit_return = 1'b0;
            if (!hold && pending > 0) begin
                if (ret_wait == 0) begin
                    credit_return = 1'b1;
                    pending--;
                    ret_wait = RET_DELAY;
                end else begin
                    ret_wait--;
                end
            end
        end
    end

    // compare on the falling edge, outputs settled
    always @(negedge reset) begin
        if (!clk) begin
            assert (out_valid !== 1'b1) else begin
                errors++;
                $display("out_valid went high while reset was asserted");
            end
        end else if (out_valid === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("extra word %h on the output with none expected", out_word);
            end
            if (exp_q.size() != 0) begin
                exp_w = exp_q.pop_front();
                checked++;
                assert (out_word === exp_w) else begin
                    errors++;
                    $display("Fail %s: expected %h, actual %h", test_name, exp_w, out_word);
                end
            end
            pending++;
            if (hold) begin
                held_rx++;
            end
        end
    end

    // watchdog
    initial begin
        #(WATCHDOG);
        $display("watchdog expired before the run completed");
        $display("Test failed");
        $finish;
    end

    initial begin
        spike      = '0;
        win_strobe = 1'b0;
        lfsr       = 32'h48d4;
        hold       = 1'b0;
        held_rx    = 0;
        kept       = 0;
        dropped    = 0;
        pending    = 0;
        errors     = 0;
        checked    = 0;
        test_name  = "reset";
        for (int ch = 0; ch < `NUM_CH; ch++) begin
            tally[ch] = 0;
            coinc[ch] = 1'b0;
        end

        @(posedge clk);
        repeat (4) @(posedge reset);

        // window 0 has no spikes, last pass only closes the final window
        for (int w = 1; w <= NUM_WIN + 1; w++) begin
            if (w >= 5 && w <= 7) begin
                test_name = "credit_limit";
            end else if (w >= 10 && w <= 14) begin
                test_name = "overflow";
            end else begin
                test_name = "counting";
            end
            if (is_held(w) && !hold) begin
                hold    = 1'b1;
                held_rx = 0;
                kept    = 0;
                dropped = 0;
            end
            queue_close(w - 1);
            for (int ch = 0; ch < `NUM_CH; ch++) begin
                tally[ch] = (w <= NUM_WIN) ? draw_bits(4) : 0;
                coinc[ch] = (draw_bits(1) != 0);
            end
            drive_cycles(0, HALF);
            if (hold && !is_held(w + 1)) begin
                release_credits();
            end
            drive_cycles(HALF, WIN_LEN);
        end

        // drain, then a quiet stretch to catch extra words
        for (int i = 0; i < 4 * WIN_LEN && exp_q.size() != 0; i++) begin
            @(posedge reset);
        end
        repeat (WIN_LEN) @(posedge reset);
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected words never appeared on the output", exp_q.size());
        end

        $display("%0d errors, %0d words checked", errors, checked);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
